/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tsn_dgcl_tb
FLIST = tsn_dgcl.f
LOG   = sim.log
PASS  = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), pass if $(LOG) holds the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dgcl_arbiter.sv */
// dgcl arbiter
// round-robin grant over the fpu dma channels with the req/resp handshake,
// muxes the granted channel's write stream onto the burst bus
`timescale 1ns/1ps
`include "dgcl_params.svh"

module dgcl_arbiter import dgcl_ctrl_pkg::*; (
	input  logic                    fpu_clk,
	input  logic                    reset,
	input  logic [`DGCL_NUM_CH-1:0] dma_req,
	output logic [`DGCL_NUM_CH-1:0] dma_resp,
	input  logic [`DGCL_NUM_CH-1:0] dma_write_valid,
	input  logic [`DGCL_DATA_W-1:0] dma_write_data_a,
	input  logic [`DGCL_DATA_W-1:0] dma_write_data_b,
	input  logic [`DGCL_DATA_W-1:0] dma_write_data_c,
	input  logic [`DGCL_DATA_W-1:0] dma_write_data_d,
	output logic [`DGCL_NUM_CH-1:0] dma_write_ready,
	dgcl_chan_if.source             chan
);
	localparam int CH_AW = $clog2(`DGCL_NUM_CH);

	arb_state_e              state;
	logic [`DGCL_NUM_CH-1:0] grant_oh;
	logic [CH_AW-1:0]        last_ch;   // last granted, also mux select
	logic                    resp_r;
	logic [CH_AW-1:0]        next_ch;
	logic                    next_hit;
	logic [`DGCL_DATA_W-1:0] wdata [`DGCL_NUM_CH];

	assign wdata[0] = dma_write_data_a;
	assign wdata[1] = dma_write_data_b;
	assign wdata[2] = dma_write_data_c;
	assign wdata[3] = dma_write_data_d;

	// search starts one past the last grant
	always_comb begin
		logic [CH_AW-1:0] cand;
		cand = last_ch;
		next_ch = last_ch;
		next_hit = 1'b0;
		for (int k = 0; k < `DGCL_NUM_CH; k++) begin
			cand = cand + 1'b1;
			if (!next_hit && dma_req[cand]) begin
				next_hit = 1'b1;
				next_ch = cand;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// grant FSM
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state    <= ARB_IDLE;
			grant_oh <= '0;
			last_ch  <= CH_AW'(`DGCL_NUM_CH - 1);   // first search hits channel a
			resp_r   <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (next_hit) begin
						grant_oh <= `DGCL_NUM_CH'(1) << next_ch;
						last_ch  <= next_ch;
						state    <= ARB_GRANT;
					end
				end
				ARB_GRANT: begin
					resp_r <= 1'b1;   // acknowledge, opens the write stream
					if (chan.burst_done)
						state <= ARB_RELEASE;
				end
				ARB_RELEASE: begin
					if (!dma_req[last_ch]) begin
						resp_r   <= 1'b0;
						grant_oh <= '0;
						state    <= ARB_IDLE;   // resp low at least one cycle before next grant
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	assign chan.grant      = (state == ARB_GRANT) && resp_r;
	assign chan.word_valid = chan.grant && dma_write_valid[last_ch];
	assign chan.word_data  = wdata[last_ch];

	assign dma_resp        = grant_oh & {`DGCL_NUM_CH{resp_r}};
	assign dma_write_ready = grant_oh & {`DGCL_NUM_CH{chan.word_ready}};   // only to the owner

endmodule

/* dgcl_burst_rx.sv */
// dgcl burst receiver
// counts the words of each burst, classifies it by its header form and
// pushes read headers, write headers and write payload into the word queue
`timescale 1ns/1ps
`include "dgcl_params.svh"

module dgcl_burst_rx import dgcl_hdr_pkg::*, dgcl_ctrl_pkg::*; (
	input  logic      fpu_clk,
	input  logic      reset,
	dgcl_chan_if.sink chan,
	dgcl_q_if.writer  q
);
	localparam logic [`DGCL_LEN_W-1:0] ONE_WORD = 1;

	rx_state_e              state;
	logic [`DGCL_LEN_W-1:0] remain;   // words still to come
	logic                   done_r;
	logic                   accept;
	logic                   keep;
	logic                   last;
	word_kind_e             kind;
	dgcl_hdr_t              hdr;
	logic                   is_rd;
	logic                   is_wr;

	assign hdr   = dgcl_hdr_t'(chan.word_data);
	assign is_rd = hdr.form == MSG_RD_CMD;
	assign is_wr = (hdr.form == MSG_WR_CMD) && (hdr.length > ONE_WORD);

	// held low in the done cycle so the channel sees ready drop after the last word
	assign chan.word_ready = chan.grant && !q.full && !done_r;
	assign chan.burst_done = done_r;
	assign accept          = chan.word_valid && chan.word_ready;

	always_comb begin
		kind = KIND_WR_DATA;
		last = 1'b0;
		keep = 1'b0;
		case (state)
			RX_HDR: begin
				if (is_rd) begin
					kind = KIND_RD_HDR;
					last = 1'b1;
					keep = 1'b1;
				end else if (is_wr) begin
					kind = KIND_WR_HDR;
					keep = 1'b1;
				end
			end
			RX_PAYLOAD: begin
				last = remain == ONE_WORD;
				keep = 1'b1;
			end
			default: keep = 1'b0;   // dropped words
		endcase
	end

	assign q.push      = accept && keep;
	assign q.push_word = '{kind: kind, last: last, data: chan.word_data};

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state  <= RX_HDR;
			remain <= '0;
			done_r <= 1'b0;
		end else begin
			done_r <= 1'b0;
			if (accept) begin
				case (state)
					RX_HDR: begin
						if (is_rd || hdr.length <= ONE_WORD) begin
							done_r <= 1'b1;   // single word burst
						end else begin
							remain <= hdr.length - ONE_WORD;
							state  <= is_wr ? RX_PAYLOAD : RX_WAIT_DROP;
						end
					end
					default: begin
						remain <= remain - ONE_WORD;
						if (remain == ONE_WORD) begin
							done_r <= 1'b1;
							state  <= RX_HDR;
						end
					end
				endcase
			end
		end
	end

endmodule

/* dgcl_ctrl_pkg.sv */
// dgcl control package
// state encodings of the arbiter, burst receiver and dispatcher FSMs
package dgcl_ctrl_pkg;

	typedef enum logic [1:0] {ARB_IDLE, ARB_GRANT, ARB_RELEASE} arb_state_e;

	// RX_WAIT_DROP swallows the rest of an unwanted burst
	typedef enum logic [1:0] {RX_HDR, RX_PAYLOAD, RX_WAIT_DROP} rx_state_e;

	typedef enum logic [1:0] {DSP_IDLE, DSP_RCC, DSP_WCC} dsp_state_e;

endpackage

/* dgcl_dispatch.sv */
// dgcl dispatcher
// pops the word queue, issues read commands on rcc and write commands
// with their data beats on wcc
`timescale 1ns/1ps
`include "dgcl_params.svh"

module dgcl_dispatch import dgcl_hdr_pkg::*, dgcl_ctrl_pkg::*; (
	input  logic                     fpu_clk,
	input  logic                     reset,
	input  logic                     rcc_ready,
	input  logic                     wcc_ready,
	dgcl_q_if.reader                 q,
	output logic [`DGCL_DRAM_W-1:0]  rcc_dram_addr,
	output logic [`DGCL_DPRAM_W-1:0] rcc_dpram_addr,
	output logic [`DGCL_LEN_W-1:0]   rcc_length,
	output logic                     rcc_valid,
	output logic [`DGCL_DRAM_W-1:0]  wcc_dram_addr,
	output logic [`DGCL_DPRAM_W-1:0] wcc_dpram_addr,
	output logic [`DGCL_LEN_W-1:0]   wcc_length,
	output logic [`DGCL_DATA_W-1:0]  wcc_write_data,
	output logic                     wcc_valid
);
	dsp_state_e state;
	dgcl_hdr_t  head_hdr;
	logic       wcc_on;   // write header taken, beats flowing
	logic       beat;

	assign head_hdr       = dgcl_hdr_t'(q.head.data);
	assign wcc_valid      = wcc_on && !q.empty && (q.head.kind == KIND_WR_DATA);
	assign wcc_write_data = q.head.data;
	assign beat           = wcc_valid && wcc_ready;

	always_comb begin
		case (state)
			DSP_RCC:  q.pop = rcc_valid && rcc_ready;
			DSP_WCC:  q.pop = wcc_on ? beat : !q.empty;   // header first, then beats
			default:  q.pop = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////
	// command FSM
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state     <= DSP_IDLE;
			rcc_valid <= 1'b0;
			wcc_on    <= 1'b0;
		end else begin
			case (state)
				DSP_IDLE: begin
					if (!q.empty && q.head.kind == KIND_RD_HDR) begin
						rcc_valid <= 1'b1;
						state     <= DSP_RCC;
					end else if (!q.empty && q.head.kind == KIND_WR_HDR) begin
						state <= DSP_WCC;
					end
				end
				DSP_RCC: begin
					if (rcc_ready) begin
						rcc_valid <= 1'b0;
						state     <= DSP_IDLE;
					end
				end
				DSP_WCC: begin
					if (!wcc_on) begin
						wcc_on <= !q.empty;
					end else if (beat && q.head.last) begin
						wcc_on <= 1'b0;
						state  <= DSP_IDLE;
					end
				end
				default: state <= DSP_IDLE;
			endcase
		end
	end

	// command fields, held until the next command of the same kind
	always_ff @(posedge fpu_clk) begin
		if (state == DSP_IDLE && !q.empty && q.head.kind == KIND_RD_HDR) begin
			rcc_dram_addr  <= head_hdr.dram_addr;
			rcc_dpram_addr <= head_hdr.dpram_addr;
			rcc_length     <= head_hdr.length;
		end
		if (state == DSP_WCC && !wcc_on && !q.empty) begin
			wcc_dram_addr  <= head_hdr.dram_addr;
			wcc_dpram_addr <= head_hdr.dpram_addr;
			wcc_length     <= head_hdr.length;
		end
	end

endmodule

/* dgcl_hdr_pkg.sv */
// dgcl header package
// message forms, the 128-bit burst header layout and the queued word format
`include "dgcl_params.svh"

package dgcl_hdr_pkg;

	// header form byte, bits 79:72
	typedef enum logic [`DGCL_FORM_W-1:0] {
		MSG_RD_CMD = 8'h01,
		MSG_WR_CMD = 8'h03
	} msg_form_e;

	// what a queued word carries
	typedef enum logic [1:0] {
		KIND_RD_HDR,
		KIND_WR_HDR,
		KIND_WR_DATA
	} word_kind_e;

	// first word of every burst
	typedef struct packed {
		logic [`DGCL_DATA_W-`DGCL_FORM_W-`DGCL_LEN_W-`DGCL_DPRAM_W-`DGCL_DRAM_W-1:0] pad;
		logic [`DGCL_FORM_W-1:0]  form;        // any value, only two are kept
		logic [`DGCL_LEN_W-1:0]   length;      // burst words incl. header
		logic [`DGCL_DPRAM_W-1:0] dpram_addr;
		logic [`DGCL_DRAM_W-1:0]  dram_addr;
	} dgcl_hdr_t;

	typedef struct packed {
		word_kind_e               kind;
		logic                     last;   // final word of its command
		logic [`DGCL_DATA_W-1:0]  data;
	} dgcl_qword_t;

endpackage

/* dgcl_if.sv */
// dgcl internal interfaces
// chan: granted channel's burst stream, arbiter to burst receiver
// q: tagged word queue, burst receiver to FIFO to dispatcher
`timescale 1ns/1ps
`include "dgcl_params.svh"

interface dgcl_chan_if;
	logic                    grant;       // a channel owns the bus
	logic                    word_valid;
	logic [`DGCL_DATA_W-1:0] word_data;
	logic                    word_ready;
	logic                    burst_done;  // one cycle after last word

	modport source (output grant, word_valid, word_data, input word_ready, burst_done);
	modport sink   (input grant, word_valid, word_data, output word_ready, burst_done);
endinterface

interface dgcl_q_if import dgcl_hdr_pkg::*; ();
	logic        push;
	dgcl_qword_t push_word;
	logic        full;
	logic        empty;
	dgcl_qword_t head;   // valid while empty is low
	logic        pop;

	modport writer (output push, push_word, input full);
	modport store  (input push, push_word, pop, output full, empty, head);
	modport reader (input empty, head, output pop);
endinterface

/* dgcl_params.svh */
// dgcl parameters
// bus widths, channel count and word queue depth of the dma gather controller
`ifndef DGCL_PARAMS_SVH
`define DGCL_PARAMS_SVH

// fpu side
`define DGCL_NUM_CH   4
`define DGCL_DATA_W   128

// header field widths, lsb first: dram, dpram, length, form, pad
`define DGCL_DRAM_W   40
`define DGCL_DPRAM_W  16
`define DGCL_LEN_W    16
`define DGCL_FORM_W   8

// word queue between burst receiver and dispatcher
`define DGCL_Q_DEPTH  16

`endif

/* dgcl_word_fifo.sv */
// dgcl word FIFO
// synchronous first-word-fall-through queue of tagged words,
// push and pop may happen in the same cycle
`timescale 1ns/1ps
`include "dgcl_params.svh"

module dgcl_word_fifo import dgcl_hdr_pkg::*; (
	input  logic     fpu_clk,
	input  logic     reset,
	dgcl_q_if.store  q
);
	localparam int AW = $clog2(`DGCL_Q_DEPTH);
	localparam logic [AW:0] FULL_CNT = `DGCL_Q_DEPTH;

	dgcl_qword_t  mem [`DGCL_Q_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	assign do_push = q.push && !q.full;
	assign do_pop  = q.pop && !q.empty;
	assign q.full  = count == FULL_CNT;
	assign q.empty = count == '0;
	assign q.head  = mem[rd_ptr];   // fall through

	always_ff @(posedge fpu_clk) begin
		if (do_push)
			mem[wr_ptr] <= q.push_word;
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* tsn_dgcl.f */
+incdir+.
dgcl_hdr_pkg.sv
dgcl_ctrl_pkg.sv
dgcl_if.sv
dgcl_arbiter.sv
dgcl_burst_rx.sv
dgcl_word_fifo.sv
dgcl_dispatch.sv
tsn_dgcl.sv
tsn_dgcl_props.sv
tsn_dgcl_tb.sv

/* tsn_dgcl.sv */
// tsn_dgcl top level
// single clock dma gather controller: fpu dma channels a..d in,
// risc side read and write command ports out
`timescale 1ns/1ps
`include "dgcl_params.svh"

module tsn_dgcl (
	input  logic                     fpu_clk,
	input  logic                     reset,

	// fpu dma channels, bit 0 is channel a
	input  logic [`DGCL_NUM_CH-1:0]  dma_req,
	output logic [`DGCL_NUM_CH-1:0]  dma_resp,
	input  logic [`DGCL_NUM_CH-1:0]  dma_write_valid,
	input  logic [`DGCL_DATA_W-1:0]  dma_write_data_a,
	input  logic [`DGCL_DATA_W-1:0]  dma_write_data_b,
	input  logic [`DGCL_DATA_W-1:0]  dma_write_data_c,
	input  logic [`DGCL_DATA_W-1:0]  dma_write_data_d,
	output logic [`DGCL_NUM_CH-1:0]  dma_write_ready,

	// risc read command
	output logic [`DGCL_DRAM_W-1:0]  rcc_dram_addr,
	output logic [`DGCL_DPRAM_W-1:0] rcc_dpram_addr,
	output logic [`DGCL_LEN_W-1:0]   rcc_length,
	input  logic                     rcc_ready,
	output logic                     rcc_valid,

	// risc write command and data beats
	output logic [`DGCL_DRAM_W-1:0]  wcc_dram_addr,
	output logic [`DGCL_DPRAM_W-1:0] wcc_dpram_addr,
	output logic [`DGCL_LEN_W-1:0]   wcc_length,
	output logic [`DGCL_DATA_W-1:0]  wcc_write_data,
	input  logic                     wcc_ready,
	output logic                     wcc_valid
);
	dgcl_chan_if chan_bus ();
	dgcl_q_if    q_bus ();

	dgcl_arbiter u_arb (
		.fpu_clk          (fpu_clk),
		.reset            (reset),
		.dma_req          (dma_req),
		.dma_resp         (dma_resp),
		.dma_write_valid  (dma_write_valid),
		.dma_write_data_a (dma_write_data_a),
		.dma_write_data_b (dma_write_data_b),
		.dma_write_data_c (dma_write_data_c),
		.dma_write_data_d (dma_write_data_d),
		.dma_write_ready  (dma_write_ready),
		.chan             (chan_bus)
	);

	dgcl_burst_rx u_rx (.fpu_clk(fpu_clk), .reset(reset), .chan(chan_bus), .q(q_bus));

	dgcl_word_fifo u_fifo (.fpu_clk(fpu_clk), .reset(reset), .q(q_bus));

	dgcl_dispatch u_dsp (
		.fpu_clk        (fpu_clk),
		.reset          (reset),
		.rcc_ready      (rcc_ready),
		.wcc_ready      (wcc_ready),
		.q              (q_bus),
		.rcc_dram_addr  (rcc_dram_addr),
		.rcc_dpram_addr (rcc_dpram_addr),
		.rcc_length     (rcc_length),
		.rcc_valid      (rcc_valid),
		.wcc_dram_addr  (wcc_dram_addr),
		.wcc_dpram_addr (wcc_dpram_addr),
		.wcc_length     (wcc_length),
		.wcc_write_data (wcc_write_data),
		.wcc_valid      (wcc_valid)
	);

endmodule

/* tsn_dgcl_props.sv */
// tsn_dgcl handshake properties
// bound to the top level, checks channel ownership and the rcc hold rule
`timescale 1ns/1ps
`include "dgcl_params.svh"

module tsn_dgcl_props (
	input logic                     fpu_clk,
	input logic                     reset,
	input logic [`DGCL_NUM_CH-1:0]  dma_resp,
	input logic [`DGCL_NUM_CH-1:0]  dma_write_ready,
	input logic                     rcc_valid,
	input logic                     rcc_ready,
	input logic [`DGCL_DRAM_W-1:0]  rcc_dram_addr,
	input logic [`DGCL_DPRAM_W-1:0] rcc_dpram_addr,
	input logic [`DGCL_LEN_W-1:0]   rcc_length
);
	// one channel owns the bus at a time
	a_resp_onehot: assert property (@(posedge fpu_clk) disable iff (reset)
		$onehot0(dma_resp))
		else $error("more than one dma_resp bit is high");

	a_ready_owner: assert property (@(posedge fpu_clk) disable iff (reset)
		(dma_write_ready & ~dma_resp) == '0)
		else $error("dma_write_ready is high on a channel without dma_resp");

	// waiting read command keeps its fields
	a_rcc_hold: assert property (@(posedge fpu_clk) disable iff (reset)
		rcc_valid && !rcc_ready |=> rcc_valid && $stable(rcc_dram_addr)
			&& $stable(rcc_dpram_addr) && $stable(rcc_length))
		else $error("rcc command changed or dropped before rcc_ready");
endmodule

bind tsn_dgcl tsn_dgcl_props u_props (
	.fpu_clk        (fpu_clk),
	.reset          (reset),
	.dma_resp       (dma_resp),
	.dma_write_ready(dma_write_ready),
	.rcc_valid      (rcc_valid),
	.rcc_ready      (rcc_ready),
	.rcc_dram_addr  (rcc_dram_addr),
	.rcc_dpram_addr (rcc_dpram_addr),
	.rcc_length     (rcc_length)
);

/* tsn_dgcl_tb.sv */
// tsn_dgcl testbench
// drives the fpu channels with read, write and dropped bursts and checks
// rcc and wcc against a reference model of the gather rules
`timescale 1ns/1ps
`include "dgcl_params.svh"

module tsn_dgcl_tb import dgcl_hdr_pkg::*; ();
	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY  = 2;
	localparam int SEED       = 70183;
	localparam int MAX_BURST  = 16;
	localparam int MAX_WORDS  = 1 + 5 + 17 + 41 + 5;   // test 5 at its longest
	localparam int WD_CYCLES  = MAX_WORDS * 20 + 500;

	logic                     fpu_clk = 1'b0;
	logic                     reset   = 1'b1;
	logic [`DGCL_NUM_CH-1:0]  dma_req = '0;
	logic [`DGCL_NUM_CH-1:0]  dma_write_valid = '0;
	logic [`DGCL_DATA_W-1:0]  wdata [`DGCL_NUM_CH] = '{default: '0};
	logic                     rcc_ready = 1'b1;
	logic                     wcc_ready = 1'b1;
	logic [`DGCL_NUM_CH-1:0]  dma_resp;
	logic [`DGCL_NUM_CH-1:0]  dma_write_ready;
	logic [`DGCL_DRAM_W-1:0]  rcc_dram_addr;
	logic [`DGCL_DPRAM_W-1:0] rcc_dpram_addr;
	logic [`DGCL_LEN_W-1:0]   rcc_length;
	logic                     rcc_valid;
	logic [`DGCL_DRAM_W-1:0]  wcc_dram_addr;
	logic [`DGCL_DPRAM_W-1:0] wcc_dpram_addr;
	logic [`DGCL_LEN_W-1:0]   wcc_length;
	logic [`DGCL_DATA_W-1:0]  wcc_write_data;
	logic                     wcc_valid;

	logic [`DGCL_DATA_W-1:0]  burst_mem [`DGCL_NUM_CH][MAX_BURST];   // word 0 is the header
	logic [4:0]               burst_len [`DGCL_NUM_CH];
	dgcl_hdr_t                exp_rd [$];
	dgcl_hdr_t                exp_wr [$];
	logic [`DGCL_DATA_W-1:0]  exp_beat [$];
	dgcl_hdr_t                cur_wr;
	int                       beats_left = 0;
	int                       errors = 0;
	int                       tnum = 0;
	int                       tests_failed = 0;
	int                       err_mark = 0;
	logic                     stall_en = 1'b0;
	logic                     idle_chk = 1'b0;

	tsn_dgcl u_dut (
		.fpu_clk (fpu_clk), .reset (reset),
		.dma_req (dma_req), .dma_resp (dma_resp), .dma_write_valid (dma_write_valid),
		.dma_write_data_a (wdata[0]), .dma_write_data_b (wdata[1]),
		.dma_write_data_c (wdata[2]), .dma_write_data_d (wdata[3]),
		.dma_write_ready (dma_write_ready),
		.rcc_dram_addr (rcc_dram_addr), .rcc_dpram_addr (rcc_dpram_addr),
		.rcc_length (rcc_length), .rcc_ready (rcc_ready), .rcc_valid (rcc_valid),
		.wcc_dram_addr (wcc_dram_addr), .wcc_dpram_addr (wcc_dpram_addr),
		.wcc_length (wcc_length), .wcc_write_data (wcc_write_data),
		.wcc_ready (wcc_ready), .wcc_valid (wcc_valid)
	);

	always #(CLK_PERIOD / 2) fpu_clk = ~fpu_clk;

	// risc side ready, random stalls when enabled
	always @(posedge fpu_clk) begin
		#(DRIVE_DLY);
		if (stall_en) begin
			rcc_ready = ($urandom % 3) != 0;
			wcc_ready = ($urandom % 3) != 0;
		end else begin
			rcc_ready = 1'b1;
			wcc_ready = 1'b1;
		end
	end

	initial begin
		repeat (WD_CYCLES) @(posedge fpu_clk);
		$display("ERROR: timeout after %0d cycles, a handshake or drain never finished", WD_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	////////////////////////////////////////////////////////////////////
	// reference model and checks
	////////////////////////////////////////////////////////////////////
	function automatic void predict_burst(input logic [1:0] ch);
		dgcl_hdr_t hdr;
		hdr = burst_mem[ch][0];
		if (hdr.form == MSG_RD_CMD) begin
			exp_rd.push_back(hdr);
		end else if (hdr.form == MSG_WR_CMD && hdr.length >= 16'd2) begin
			exp_wr.push_back(hdr);
			for (logic [4:0] w = 5'd1; w < 5'(hdr.length); w++)
				exp_beat.push_back(burst_mem[ch][w[3:0]]);
		end
		// other forms and short writes vanish
	endfunction

	task automatic check_rd_cmd(input dgcl_hdr_t exp, input dgcl_hdr_t got);
		if (got.dram_addr !== exp.dram_addr) begin
			errors++;
			$display("[FAIL] %0t rcc_dram_addr exp %h got %h", $time, exp.dram_addr, got.dram_addr);
		end
		if (got.dpram_addr !== exp.dpram_addr) begin
			errors++;
			$display("[FAIL] %0t rcc_dpram_addr exp %h got %h", $time, exp.dpram_addr, got.dpram_addr);
		end
		if (got.length !== exp.length) begin
			errors++;
			$display("[FAIL] %0t rcc_length exp %h got %h", $time, exp.length, got.length);
		end
	endtask

	task automatic check_wr_cmd(input dgcl_hdr_t exp, input dgcl_hdr_t got);
		if (got.dram_addr !== exp.dram_addr) begin
			errors++;
			$display("[FAIL] %0t wcc_dram_addr exp %h got %h", $time, exp.dram_addr, got.dram_addr);
		end
		if (got.dpram_addr !== exp.dpram_addr) begin
			errors++;
			$display("[FAIL] %0t wcc_dpram_addr exp %h got %h", $time, exp.dpram_addr, got.dpram_addr);
		end
		if (got.length !== exp.length) begin
			errors++;
			$display("[FAIL] %0t wcc_length exp %h got %h", $time, exp.length, got.length);
		end
	endtask

	task automatic check_wr_beat(input logic [`DGCL_DATA_W-1:0] exp, input logic [`DGCL_DATA_W-1:0] got);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t wcc_write_data exp %h got %h", $time, exp, got);
		end
	endtask

	task automatic check_idle(input string name, input logic [`DGCL_NUM_CH-1:0] got);
		if (got !== '0) begin
			errors++;
			$display("[FAIL] %0t %s exp %h got %h", $time, name, `DGCL_NUM_CH'(0), got);
		end
	endtask

	// negedge values equal those at the next transfer edge
	always @(negedge fpu_clk) begin
		dgcl_hdr_t got;
		if (!reset) begin
			if (idle_chk) begin
				check_idle("dma_resp", dma_resp);
				check_idle("dma_write_ready", dma_write_ready);
				check_idle("rcc_valid", `DGCL_NUM_CH'(rcc_valid));
				check_idle("wcc_valid", `DGCL_NUM_CH'(wcc_valid));
			end
			if (rcc_valid && rcc_ready) begin
				got = '0;
				got.dram_addr  = rcc_dram_addr;
				got.dpram_addr = rcc_dpram_addr;
				got.length     = rcc_length;
				if (exp_rd.size() == 0) begin
					errors++;
					$display("ERROR %0t: read command on rcc while none was expected", $time);
				end else begin
					check_rd_cmd(exp_rd.pop_front(), got);
				end
			end
			if (wcc_valid && wcc_ready) begin
				got = '0;
				got.dram_addr  = wcc_dram_addr;
				got.dpram_addr = wcc_dpram_addr;
				got.length     = wcc_length;
				if (beats_left == 0 && exp_wr.size() != 0) begin
					cur_wr     = exp_wr.pop_front();
					beats_left = int'(cur_wr.length) - 1;
				end
				if (beats_left == 0 || exp_beat.size() == 0) begin
					errors++;
					$display("ERROR %0t: write beat on wcc while none was expected", $time);
				end else begin
					check_wr_cmd(cur_wr, got);
					check_wr_beat(exp_beat.pop_front(), wcc_write_data);
					beats_left--;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// channel side stimulus
	////////////////////////////////////////////////////////////////////
	task automatic load_burst(input logic [1:0] ch, input logic [7:0] form,
			input logic [15:0] len, input logic [39:0] dram, input logic [15:0] dpram);
		dgcl_hdr_t hdr;
		hdr            = '0;
		hdr.form       = form;
		hdr.length     = len;
		hdr.dpram_addr = dpram;
		hdr.dram_addr  = dram;
		burst_mem[ch][0] = hdr;
		if (form == MSG_RD_CMD || len < 16'd2)
			burst_len[ch] = 5'd1;   // header only
		else
			burst_len[ch] = len[4:0];
		for (logic [4:0] w = 5'd1; w < burst_len[ch]; w++)
			burst_mem[ch][w[3:0]] = {$urandom, $urandom, $urandom, $urandom};
	endtask

	// req, wait resp, stream the burst, then release
	task automatic drive_burst(input logic [1:0] ch);
		@(posedge fpu_clk);
		#(DRIVE_DLY);
		dma_req[ch] = 1'b1;
		@(negedge fpu_clk);
		while (!dma_resp[ch]) @(negedge fpu_clk);
		for (logic [4:0] w = 5'd0; w < burst_len[ch]; w++) begin
			@(posedge fpu_clk);
			#(DRIVE_DLY);
			wdata[ch]           = burst_mem[ch][w[3:0]];
			dma_write_valid[ch] = 1'b1;
			@(negedge fpu_clk);
			while (!dma_write_ready[ch]) @(negedge fpu_clk);
		end
		@(posedge fpu_clk);
		#(DRIVE_DLY);
		dma_write_valid[ch] = 1'b0;
		@(negedge fpu_clk);
		while (dma_write_ready[ch]) @(negedge fpu_clk);
		@(posedge fpu_clk);
		#(DRIVE_DLY);
		dma_req[ch] = 1'b0;
		@(negedge fpu_clk);
		while (dma_resp[ch]) @(negedge fpu_clk);
	endtask

	task automatic send_burst(input logic [1:0] ch, input logic [7:0] form,
			input logic [15:0] len, input logic [39:0] dram, input logic [15:0] dpram);
		load_burst(ch, form, len, dram, dpram);
		predict_burst(ch);
		drive_burst(ch);
	endtask

	// all channels request together, expected in grant order a..d
	task automatic send_all_four(input logic [7:0] form, input logic [15:0] len,
			input logic [39:0] base);
		for (int k = 0; k < `DGCL_NUM_CH; k++)
			load_burst(k[1:0], form, len, base + 40'(k * 32'h100), 16'(k * 8));
		for (int k = 0; k < `DGCL_NUM_CH; k++)
			predict_burst(k[1:0]);
		fork
			drive_burst(2'd0);
			drive_burst(2'd1);
			drive_burst(2'd2);
			drive_burst(2'd3);
		join
	endtask

	task automatic wait_drain();
		while (exp_rd.size() != 0 || exp_wr.size() != 0 || exp_beat.size() != 0)
			@(negedge fpu_clk);
	endtask

	task automatic finish_test(input string name);
		tnum++;
		if (errors != err_mark)
			tests_failed++;
		$display("test %0d %s: %s", tnum, name, (errors == err_mark) ? "ok" : "FAILED");
		err_mark = errors;
	endtask

	initial begin
		void'($urandom(SEED));
		repeat (3) @(posedge fpu_clk);
		#(DRIVE_DLY);
		reset = 1'b0;

		idle_chk = 1'b1;
		repeat (8) @(negedge fpu_clk);
		idle_chk = 1'b0;
		finish_test("idle after reset");

		send_burst(2'd0, MSG_RD_CMD, 16'h0020, 40'h12_3456_7890, 16'h0100);
		wait_drain();
		finish_test("read on channel a");

		send_burst(2'd2, MSG_WR_CMD, 16'd5, 40'h00_cafe_0000, 16'h0200);
		wait_drain();
		finish_test("write of 5 on channel c");

		// channel d granted last, so the next search starts at a
		send_burst(2'd3, MSG_RD_CMD, 16'h0001, 40'h0f_0000_0000, 16'h00f0);
		send_all_four(MSG_RD_CMD, 16'h0010, 40'h10_0000_0000);
		send_all_four(MSG_WR_CMD, 16'd3, 40'h20_0000_0000);
		wait_drain();
		finish_test("round robin over four channels");

		stall_en = 1'b1;
		for (int k = 0; k < 6; k++) begin
			if (k == 3)
				send_burst(k[1:0], MSG_RD_CMD, 16'h0008, 40'h30_0000_0000, 16'h0300);
			else
				send_burst(k[1:0], MSG_WR_CMD, 16'(2 + $urandom % 7),
					40'h40_0000_0000 + 40'(k), 16'(k));
		end
		wait_drain();
		stall_en = 1'b0;
		finish_test("write bursts under random stalls");

		send_burst(2'd1, 8'h07, 16'd3, 40'h50_0000_0000, 16'h0500);   // unknown form
		send_burst(2'd1, MSG_WR_CMD, 16'd1, 40'h51_0000_0000, 16'h0510);
		send_burst(2'd3, MSG_RD_CMD, 16'h0004, 40'h52_0000_0000, 16'h0520);
		wait_drain();
		finish_test("dropped bursts");

		$display("summary: %0d tests, %0d failed, %0d errors", tnum, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
